//--- xbar_pkg.sv
// ================================================
// Register map, bus structs and enums shared by
// the crossbar blocks; referenced by scoped names
// ================================================
package xbar_pkg;

  localparam int REG_AWIDTH    = 14;
  localparam int REG_DWIDTH    = 32;
  localparam int DATA_W        = 64;
  localparam int ROUTE_ENTRIES = 32;  // Local bank 0..15, remote bank 16..31

  localparam logic [REG_DWIDTH-1:0] XBAR_VERSION = 32'd1;

  // Offsets from REG_BASE
  localparam logic [REG_AWIDTH-1:0] REG_VERSION    = 14'h10;
  localparam logic [REG_AWIDTH-1:0] REG_NUM_PORTS  = 14'h14;
  localparam logic [REG_AWIDTH-1:0] REG_LOCAL_ADDR = 14'h18;
  localparam logic [REG_AWIDTH-1:0] ROUTE_BASE     = 14'h20;

  typedef struct packed {
    logic                  req;
    logic [REG_AWIDTH-1:0] addr;
    logic [REG_DWIDTH-1:0] data;
  } reg_wr_t;

  typedef struct packed {
    logic                  req;
    logic [REG_AWIDTH-1:0] addr;
  } reg_rd_req_t;

  typedef struct packed {
    logic                  resp;
    logic [REG_DWIDTH-1:0] data;
  } reg_rd_resp_t;

  typedef struct packed {
    logic                  stb;
    logic [4:0]            idx;   // Routing entry index
    logic [REG_DWIDTH-1:0] data;
  } set_bus_t;

  typedef struct packed {
    logic       stb;
    logic [4:0] idx;
  } rb_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic              last;
  } axis_beat_t;

  typedef enum logic [2:0] {
    RK_NONE,
    RK_VERSION,
    RK_NUM_PORTS,
    RK_LOCAL_ADDR,
    RK_ROUTE
  } reg_kind_e;

  typedef enum logic [1:0] {
    SW_IDLE,
    SW_REQUEST,
    SW_FORWARD
  } sw_state_e;

  // Width of an index into n items, never below one bit
  function automatic int idx_width(input int n);
    return (n > 1) ? $clog2(n) : 1;
  endfunction

endpackage

//--- xbar_regport_decode.sv
// ================================================
// Register port decoder that holds the global
// registers and turns route accesses into strobes
// ================================================
module xbar_regport_decode #(
  parameter logic [xbar_pkg::REG_AWIDTH-1:0] REG_BASE = '0,
  parameter int NUM_INPUTS = 2
) (
  input  logic                              clk,
  input  logic                              reset,
  input  xbar_pkg::reg_wr_t                 i_wr,
  input  xbar_pkg::reg_rd_req_t             i_rd,
  output xbar_pkg::set_bus_t                o_set,
  output xbar_pkg::rb_req_t                 o_rb,
  output logic [xbar_pkg::REG_DWIDTH-1:0]   o_local_addr,
  output xbar_pkg::reg_rd_resp_t            o_rd_resp
);
  localparam int AW = xbar_pkg::REG_AWIDTH;
  localparam int DW = xbar_pkg::REG_DWIDTH;

  localparam logic [AW-1:0] A_VERSION    = REG_BASE + xbar_pkg::REG_VERSION;
  localparam logic [AW-1:0] A_NUM_PORTS  = REG_BASE + xbar_pkg::REG_NUM_PORTS;
  localparam logic [AW-1:0] A_LOCAL_ADDR = REG_BASE + xbar_pkg::REG_LOCAL_ADDR;
  localparam logic [AW-1:0] A_ROUTE      = REG_BASE + xbar_pkg::ROUTE_BASE;
  localparam logic [AW-1:0] ROUTE_SPAN   = AW'(xbar_pkg::ROUTE_ENTRIES * 4);

  xbar_pkg::reg_kind_e wr_kind;
  xbar_pkg::reg_kind_e rd_kind;
  logic [AW-1:0]       wr_offs;
  logic [AW-1:0]       rd_offs;
  logic [DW-1:0]       local_addr_q;
  logic                resp_q;
  logic [DW-1:0]       data_q;

  function automatic xbar_pkg::reg_kind_e classify(input logic [AW-1:0] addr);
    logic [AW-1:0]       offs;
    xbar_pkg::reg_kind_e kind;
    offs = addr - A_ROUTE;  // Wraps high for addresses below the table
    kind = xbar_pkg::RK_NONE;
    if (addr == A_VERSION) kind = xbar_pkg::RK_VERSION;
    else if (addr == A_NUM_PORTS) kind = xbar_pkg::RK_NUM_PORTS;
    else if (addr == A_LOCAL_ADDR) kind = xbar_pkg::RK_LOCAL_ADDR;
    else if (offs < ROUTE_SPAN && offs[1:0] == 2'b00) kind = xbar_pkg::RK_ROUTE;
    return kind;
  endfunction

  always_comb begin
    wr_kind = classify(i_wr.addr);
    rd_kind = classify(i_rd.addr);
    wr_offs = i_wr.addr - A_ROUTE;
    rd_offs = i_rd.addr - A_ROUTE;
    // Route accesses go straight to the table in the request cycle
    o_set.stb  = i_wr.req && (wr_kind == xbar_pkg::RK_ROUTE);
    o_set.idx  = wr_offs[6:2];
    o_set.data = i_wr.data;
    o_rb.stb   = i_rd.req && (rd_kind == xbar_pkg::RK_ROUTE);
    o_rb.idx   = rd_offs[6:2];
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      local_addr_q <= '0;
      resp_q       <= 1'b0;
    end else begin
      if (i_wr.req && wr_kind == xbar_pkg::RK_LOCAL_ADDR) local_addr_q <= i_wr.data;
      resp_q <= i_rd.req && (rd_kind inside {xbar_pkg::RK_VERSION, xbar_pkg::RK_NUM_PORTS,
                                             xbar_pkg::RK_LOCAL_ADDR});
    end
  end

  always_ff @(posedge clk) begin
    case (rd_kind)
      xbar_pkg::RK_VERSION:   data_q <= xbar_pkg::XBAR_VERSION;
      xbar_pkg::RK_NUM_PORTS: data_q <= DW'(NUM_INPUTS);
      default:                data_q <= local_addr_q;
    endcase
  end

  assign o_local_addr = local_addr_q;
  assign o_rd_resp    = '{resp: resp_q, data: data_q};

  // Simultaneous read and write never mix a route access with a global one
  a_kind_mix: assert property (@(posedge clk) disable iff (reset)
    !(i_wr.req && i_rd.req &&
      (((wr_kind == xbar_pkg::RK_ROUTE) && (rd_kind inside {xbar_pkg::RK_VERSION,
          xbar_pkg::RK_NUM_PORTS, xbar_pkg::RK_LOCAL_ADDR})) ||
       ((rd_kind == xbar_pkg::RK_ROUTE) && (wr_kind inside {xbar_pkg::RK_VERSION,
          xbar_pkg::RK_NUM_PORTS, xbar_pkg::RK_LOCAL_ADDR})))));

endmodule

//--- xbar_route_table.sv
// ================================================
// Routing table: two 16-entry banks, per-lane
// lookup of the output port and registered readback
// ================================================
module xbar_route_table #(
  parameter int NUM_INPUTS  = 2,
  parameter int NUM_OUTPUTS = 2,
  localparam int PW = xbar_pkg::idx_width(NUM_OUTPUTS)
) (
  input  logic                              clk,
  input  logic                              reset,
  input  xbar_pkg::set_bus_t                i_set,
  input  xbar_pkg::rb_req_t                 i_rb,
  input  logic [xbar_pkg::REG_DWIDTH-1:0]   i_local_addr,
  input  logic [NUM_INPUTS-1:0][15:0]       i_dst,
  output logic [NUM_INPUTS-1:0][PW-1:0]     o_port,
  output xbar_pkg::reg_rd_resp_t            o_rd_resp
);
  localparam int DW = xbar_pkg::REG_DWIDTH;

  logic [PW-1:0] entry_q [xbar_pkg::ROUTE_ENTRIES];
  logic          resp_q;
  logic [DW-1:0] data_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int e = 0; e < xbar_pkg::ROUTE_ENTRIES; e++) entry_q[e] <= '0;
    end else if (i_set.stb) begin
      entry_q[i_set.idx] <= i_set.data[PW-1:0];
    end
  end

  // Lookup is combinational so the switch can latch it in the same cycle
  always_comb begin
    for (int i = 0; i < NUM_INPUTS; i++) begin
      if (i_dst[i][15:8] == i_local_addr[7:0])
        o_port[i] = entry_q[{1'b0, i_dst[i][3:0]}];   // Local bank
      else
        o_port[i] = entry_q[{1'b1, i_dst[i][11:8]}];  // Remote bank
    end
  end

  always_ff @(posedge clk) begin
    if (reset) resp_q <= 1'b0;
    else resp_q <= i_rb.stb;
  end

  always_ff @(posedge clk) begin
    if (i_rb.stb) data_q <= DW'(entry_q[i_rb.idx]);
  end

  assign o_rd_resp = '{resp: resp_q, data: data_q};

  a_entry_range: assert property (@(posedge clk) disable iff (reset)
    i_set.stb |-> (i_set.data < DW'(NUM_OUTPUTS)));

endmodule

//--- xbar_switch.sv
// ================================================
// Packet switch: one FSM per input, a round-robin
// lock per output and the beat steering between them
// ================================================
module xbar_switch #(
  parameter int NUM_INPUTS  = 2,
  parameter int NUM_OUTPUTS = 2,
  localparam int PW = xbar_pkg::idx_width(NUM_OUTPUTS)
) (
  input  logic                                   clk,
  input  logic                                   reset,
  input  xbar_pkg::axis_beat_t [NUM_INPUTS-1:0]  i_axis,
  input  logic [NUM_INPUTS-1:0]                  i_tvalid,
  input  logic [NUM_INPUTS-1:0][PW-1:0]          i_port,
  output logic [NUM_INPUTS-1:0][15:0]            o_dst,
  output logic [NUM_INPUTS-1:0]                  o_in_ready,
  output xbar_pkg::axis_beat_t [NUM_OUTPUTS-1:0] o_axis,
  output logic [NUM_OUTPUTS-1:0]                 o_tvalid,
  input  logic [NUM_OUTPUTS-1:0]                 i_out_ready
);
  localparam int IW = xbar_pkg::idx_width(NUM_INPUTS);

  xbar_pkg::sw_state_e state_q [NUM_INPUTS];
  logic [PW-1:0]       port_q [NUM_INPUTS];   // Target output of the held packet
  logic [NUM_OUTPUTS-1:0] busy_q;
  logic [IW-1:0]       owner_q [NUM_OUTPUTS];
  logic [IW-1:0]       last_q [NUM_OUTPUTS];   // Previous winner, for round-robin
  logic [NUM_OUTPUTS-1:0][NUM_INPUTS-1:0] req;
  logic [NUM_OUTPUTS-1:0][NUM_INPUTS-1:0] fwd;
  logic [NUM_OUTPUTS-1:0] gnt_vld;
  logic [IW-1:0]       gnt_idx [NUM_OUTPUTS];
  logic [NUM_INPUTS-1:0] granted;
  logic [NUM_INPUTS-1:0] in_xfer;
  logic [NUM_OUTPUTS-1:0] out_done;

  always_comb begin
    for (int o = 0; o < NUM_OUTPUTS; o++) begin
      for (int i = 0; i < NUM_INPUTS; i++) begin
        req[o][i] = (state_q[i] == xbar_pkg::SW_REQUEST) && (port_q[i] == PW'(o));
        fwd[o][i] = (state_q[i] == xbar_pkg::SW_FORWARD) && (port_q[i] == PW'(o));
      end
    end
  end

  // Search starts just after the last winner, only on unlocked outputs
  always_comb begin
    int cand;
    for (int o = 0; o < NUM_OUTPUTS; o++) begin
      gnt_vld[o] = 1'b0;
      gnt_idx[o] = '0;
      for (int k = 1; k <= NUM_INPUTS; k++) begin
        cand = (int'(last_q[o]) + k) % NUM_INPUTS;
        if (!busy_q[o] && !gnt_vld[o] && req[o][cand]) begin
          gnt_vld[o] = 1'b1;
          gnt_idx[o] = IW'(cand);
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < NUM_INPUTS; i++) begin
      o_dst[i]      = i_axis[i].data[15:0];   // First-beat destination for lookup
      granted[i]    = gnt_vld[port_q[i]] && (gnt_idx[port_q[i]] == IW'(i));
      o_in_ready[i] = (state_q[i] == xbar_pkg::SW_FORWARD) && i_out_ready[port_q[i]];
      in_xfer[i]    = i_tvalid[i] && o_in_ready[i];
    end
    for (int o = 0; o < NUM_OUTPUTS; o++) begin
      o_axis[o]   = i_axis[owner_q[o]];
      o_tvalid[o] = busy_q[o] && i_tvalid[owner_q[o]];
      out_done[o] = o_tvalid[o] && i_out_ready[o] && o_axis[o].last;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NUM_INPUTS; i++) begin
        state_q[i] <= xbar_pkg::SW_IDLE;
        port_q[i]  <= '0;
      end
      busy_q <= '0;
      for (int o = 0; o < NUM_OUTPUTS; o++) begin
        owner_q[o] <= '0;
        last_q[o]  <= IW'(NUM_INPUTS - 1);  // Input 0 wins first
      end
    end else begin
      for (int i = 0; i < NUM_INPUTS; i++) begin
        case (state_q[i])
          xbar_pkg::SW_IDLE: begin
            if (i_tvalid[i]) begin
              state_q[i] <= xbar_pkg::SW_REQUEST;
              port_q[i]  <= i_port[i];
            end
          end
          xbar_pkg::SW_REQUEST: if (granted[i]) state_q[i] <= xbar_pkg::SW_FORWARD;
          xbar_pkg::SW_FORWARD: begin
            if (in_xfer[i] && i_axis[i].last) state_q[i] <= xbar_pkg::SW_IDLE;
          end
          default: state_q[i] <= xbar_pkg::SW_IDLE;
        endcase
      end
      for (int o = 0; o < NUM_OUTPUTS; o++) begin
        if (gnt_vld[o]) begin
          busy_q[o]  <= 1'b1;
          owner_q[o] <= gnt_idx[o];
          last_q[o]  <= gnt_idx[o];
        end else if (out_done[o]) begin
          busy_q[o] <= 1'b0;   // Released on the last beat
        end
      end
    end
  end

  for (genvar o = 0; o < NUM_OUTPUTS; o++) begin : g_out_chk
    a_one_owner: assert property (@(posedge clk) disable iff (reset)
      $onehot0(fwd[o]) && ((|fwd[o]) == busy_q[o]));
    a_valid_hold: assert property (@(posedge clk) disable iff (reset)
      (o_tvalid[o] && !i_out_ready[o]) |=> o_tvalid[o]);
  end

endmodule

//--- xbar_rd_resp_merge.sv
// ================================================
// Joins the global and routing read responses
// into one registered response
// ================================================
module xbar_rd_resp_merge (
  input  logic                    clk,
  input  logic                    reset,
  input  xbar_pkg::reg_rd_resp_t  i_resp_glob,
  input  xbar_pkg::reg_rd_resp_t  i_resp_route,
  output xbar_pkg::reg_rd_resp_t  o_resp
);
  logic                              resp_q;
  logic [xbar_pkg::REG_DWIDTH-1:0]   data_q;

  always_ff @(posedge clk) begin
    if (reset) resp_q <= 1'b0;
    else resp_q <= i_resp_glob.resp | i_resp_route.resp;
  end

  // Idle sources contribute zero data
  always_ff @(posedge clk) begin
    data_q <= ({xbar_pkg::REG_DWIDTH{i_resp_glob.resp}} & i_resp_glob.data) |
              ({xbar_pkg::REG_DWIDTH{i_resp_route.resp}} & i_resp_route.data);
  end

  assign o_resp = '{resp: resp_q, data: data_q};

  a_no_overlap: assert property (@(posedge clk) disable iff (reset)
    !(i_resp_glob.resp && i_resp_route.resp));

endmodule

//--- xbar_regport_top.sv
// ================================================
// Crossbar top: register port decoder, routing
// table, packet switch and read-response merge
// ================================================
module xbar_regport_top #(
  parameter logic [xbar_pkg::REG_AWIDTH-1:0] REG_BASE = '0,
  parameter int NUM_INPUTS  = 2,
  parameter int NUM_OUTPUTS = 2
) (
  input  logic                                   clk,
  input  logic                                   reset,
  input  xbar_pkg::reg_wr_t                      i_wr,
  input  xbar_pkg::reg_rd_req_t                  i_rd,
  output xbar_pkg::reg_rd_resp_t                 o_rd_resp,
  input  xbar_pkg::axis_beat_t [NUM_INPUTS-1:0]  i_axis,
  input  logic [NUM_INPUTS-1:0]                  i_tvalid,
  output logic [NUM_INPUTS-1:0]                  o_in_ready,
  output xbar_pkg::axis_beat_t [NUM_OUTPUTS-1:0] o_axis,
  output logic [NUM_OUTPUTS-1:0]                 o_tvalid,
  input  logic [NUM_OUTPUTS-1:0]                 i_out_ready
);
  localparam int PW = xbar_pkg::idx_width(NUM_OUTPUTS);

  xbar_pkg::set_bus_t              set_bus;
  xbar_pkg::rb_req_t               rb_req;
  logic [xbar_pkg::REG_DWIDTH-1:0] local_addr;
  xbar_pkg::reg_rd_resp_t          resp_glob;
  xbar_pkg::reg_rd_resp_t          resp_route;
  logic [NUM_INPUTS-1:0][15:0]     dst;    // Lookup key per input lane
  logic [NUM_INPUTS-1:0][PW-1:0]   port;   // Looked-up output per lane

  xbar_regport_decode #(.REG_BASE(REG_BASE), .NUM_INPUTS(NUM_INPUTS)) u_decode (
    .clk(clk),
    .reset(reset),
    .i_wr(i_wr),
    .i_rd(i_rd),
    .o_set(set_bus),
    .o_rb(rb_req),
    .o_local_addr(local_addr),
    .o_rd_resp(resp_glob)
  );

  xbar_route_table #(.NUM_INPUTS(NUM_INPUTS), .NUM_OUTPUTS(NUM_OUTPUTS)) u_table (
    .clk(clk),
    .reset(reset),
    .i_set(set_bus),
    .i_rb(rb_req),
    .i_local_addr(local_addr),
    .i_dst(dst),
    .o_port(port),
    .o_rd_resp(resp_route)
  );

  xbar_switch #(.NUM_INPUTS(NUM_INPUTS), .NUM_OUTPUTS(NUM_OUTPUTS)) u_switch (
    .clk(clk),
    .reset(reset),
    .i_axis(i_axis),
    .i_tvalid(i_tvalid),
    .i_port(port),
    .o_dst(dst),
    .o_in_ready(o_in_ready),
    .o_axis(o_axis),
    .o_tvalid(o_tvalid),
    .i_out_ready(i_out_ready)
  );

  xbar_rd_resp_merge u_merge (
    .clk(clk),
    .reset(reset),
    .i_resp_glob(resp_glob),
    .i_resp_route(resp_route),
    .o_resp(o_rd_resp)
  );

endmodule

//--- tb_xbar.sv
// ==================================================
// Testbench for the crossbar top: replays the stim
// file of register accesses and packets, checks results
// ==================================================
module tb_xbar;
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [xbar_pkg::REG_AWIDTH-1:0] REG_BASE = 14'h0100;
  localparam int NUM_INPUTS  = 2;
  localparam int NUM_OUTPUTS = 4;

  logic                                   clk = 1'b0;
  logic                                   reset;
  xbar_pkg::reg_wr_t                      i_wr;
  xbar_pkg::reg_rd_req_t                  i_rd;
  xbar_pkg::reg_rd_resp_t                 o_rd_resp;
  xbar_pkg::axis_beat_t [NUM_INPUTS-1:0]  i_axis;
  logic [NUM_INPUTS-1:0]                  i_tvalid;
  logic [NUM_INPUTS-1:0]                  o_in_ready;
  xbar_pkg::axis_beat_t [NUM_OUTPUTS-1:0] o_axis;
  logic [NUM_OUTPUTS-1:0]                 o_tvalid;
  logic [NUM_OUTPUTS-1:0]                 i_out_ready = '0;

  int seed = 39;
  int num_lines = 0;
  int pkt_count = 0;
  int sent = 0;                                      // Beats handed to the DUT
  int received = 0;                                  // Beats seen on an output
  int lock_src [NUM_OUTPUTS] = '{default: -1};       // Input owning each output mid-packet
  xbar_pkg::axis_beat_t exp_q [NUM_INPUTS][$];
  int exp_port_q [NUM_INPUTS][$];

  xbar_regport_top #(
    .REG_BASE(REG_BASE),
    .NUM_INPUTS(NUM_INPUTS),
    .NUM_OUTPUTS(NUM_OUTPUTS)
  ) DUT (.*);

  always #20 clk = ~clk;

  always @(posedge clk) i_out_ready <= NUM_OUTPUTS'($random(seed));  // Random back-pressure

  task automatic fail_stop(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic compare_rd_resp(input xbar_pkg::reg_rd_resp_t got,
                                 input xbar_pkg::reg_rd_resp_t exp, input logic [31:0] addr);
    if (got.resp !== exp.resp || (exp.resp && got.data !== exp.data))
      fail_stop($sformatf("mismatch at %0t ns: read of %h gave resp %0b data %h, expected %0b %h",
                          $time, addr, got.resp, got.data, exp.resp, exp.data));
  endtask

  task automatic compare_beat(input xbar_pkg::axis_beat_t got, input xbar_pkg::axis_beat_t exp,
                              input int port);
    if (got !== exp)
      fail_stop($sformatf("mismatch at %0t ns: output %0d beat %h last %0b, expected %h last %0b",
                          $time, port, got.data, got.last, exp.data, exp.last));
  endtask

  task automatic reg_write(input logic [31:0] addr, input logic [31:0] data);
    @(posedge clk);
    i_wr <= '{req: 1'b1, addr: addr[13:0], data: data};
    @(posedge clk);
    i_wr <= '0;
  endtask

  // Response may only appear on the second edge after the request
  task automatic reg_read(input logic [31:0] addr, input logic [31:0] data, input bit mapped);
    xbar_pkg::reg_rd_resp_t exp;
    @(posedge clk);
    i_rd <= '{req: 1'b1, addr: addr[13:0]};
    @(posedge clk);
    i_rd <= '0;
    for (int c = 1; c <= 4; c++) begin
      @(negedge clk);
      exp.resp = mapped && (c == 2);
      exp.data = data;
      compare_rd_resp(o_rd_resp, exp, addr);
    end
  endtask

  // Beat layout: source, packet number, beat index, length, destination
  task automatic send_packet(input int src, input int dst, input int len, input int port);
    xbar_pkg::axis_beat_t b;
    int pkt;
    pkt = pkt_count;
    pkt_count++;
    for (int k = 0; k < len; k++) begin
      b.data = {src[7:0], pkt[7:0], k[15:0], len[15:0], dst[15:0]};
      b.last = (k == len - 1);
      exp_q[src].push_back(b);
      exp_port_q[src].push_back(port);
      sent++;
      i_axis[src]   <= b;
      i_tvalid[src] <= 1'b1;
      @(negedge clk);
      while (!o_in_ready[src]) @(negedge clk);
      @(posedge clk);
    end
    i_tvalid[src] <= 1'b0;
  endtask

  // A locked output must keep showing beats of the same source
  always @(negedge clk) begin : monitor
    int src;
    if (!reset) begin
      for (int o = 0; o < NUM_OUTPUTS; o++) begin
        if (o_tvalid[o] && i_out_ready[o]) begin
          src = (lock_src[o] < 0) ? int'(o_axis[o].data[63:56]) : lock_src[o];
          if (src >= NUM_INPUTS || exp_q[src].size() == 0)
            fail_stop($sformatf("Beat on output %0d at %0t ns belongs to no packet in flight",
                                o, $time));
          else if (exp_port_q[src][0] != o)
            fail_stop($sformatf("mismatch at %0t ns: packet of input %0d on output %0d, not %0d",
                                $time, src, o, exp_port_q[src][0]));
          else begin
            compare_beat(o_axis[o], exp_q[src].pop_front(), o);
            void'(exp_port_q[src].pop_front());
            lock_src[o] = o_axis[o].last ? -1 : src;
            received++;
          end
        end
      end
    end
  end

  initial begin : watchdog
    wait (num_lines > 0);
    repeat (16 + 200 * num_lines) @(posedge clk);
    fail_stop($sformatf("Timeout: the run exceeded %0d cycles with %0d beats outstanding",
                        16 + 200 * num_lines, sent - received));
  end

  initial begin : stimulus
    int fd;
    int n;
    string line;
    string op;
    string lines [$];
    logic [31:0] v [7];
    xbar_pkg::reg_rd_resp_t idle;
    reset    = 1'b1;
    i_wr     = '0;
    i_rd     = '0;
    i_axis   = '0;
    i_tvalid = '0;
    idle     = '0;
    fd = $fopen("xbar_stim.txt", "r");
    if (fd == 0) begin
      fail_stop("Could not open the stimulus file xbar_stim.txt");
    end else begin
      while (!$feof(fd)) begin
        if ($fgets(line, fd) > 0) lines.push_back(line);
      end
      $fclose(fd);
      num_lines = lines.size();
      repeat (16) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      if (o_tvalid != '0 || o_in_ready != '0)
        fail_stop("Stream valid or ready outputs are not low after reset");
      compare_rd_resp(o_rd_resp, idle, '0);
      foreach (lines[l]) begin
        op = "";
        n = $sscanf(lines[l], "%s %h %h %h %h %h %h %h", op, v[0], v[1], v[2], v[3], v[4],
                    v[5], v[6]);
        case (op)
          "W": reg_write(v[0], v[1]);
          "R": reg_read(v[0], v[1], 1'b1);
          "N": reg_read(v[0], '0, 1'b0);
          "P": begin
            @(posedge clk);
            send_packet(v[0], v[1], v[2], v[3]);
            while (sent != received) @(negedge clk);
          end
          "D": begin
            @(posedge clk);
            fork
              send_packet(v[0], v[1], v[2], v[6]);
              send_packet(v[3], v[4], v[5], v[6]);
            join
            while (sent != received) @(negedge clk);
          end
          default: begin
            if (n > 0 && op.len() > 0 && op.getc(0) != "#")
              fail_stop($sformatf("Unknown operation %s in the stimulus file", op));
          end
        endcase
      end
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule

//--- xbar_stim.txt
# W addr data: write | R addr data: read, expect data | N addr: unmapped, no response
# P in dst len out: one packet | D in dst len in dst len out: two inputs, one output
R 0110 00000001
R 0114 00000002
R 0118 00000000
W 0118 0000005A
R 0118 0000005A
W 012C 00000002
W 0150 00000003
W 0160 00000001
W 017C 00000001
W 018C 00000003
W 019C 00000003
R 012C 00000002
R 0150 00000003
R 0160 00000001
R 017C 00000001
R 018C 00000003
R 019C 00000003
R 0124 00000000
N 011C
N 01A0
N 0010
N 0122
P 0 5A03 4 2
P 1 5A0C 1 3
P 1 3712 3 1
P 0 5B03 2 3
P 0 0044 2 1
D 0 5A03 5 1 5A03 6 2
D 0 1F40 3 1 5B03 4 3

//--- project.f
xbar_pkg.sv
xbar_regport_decode.sv
xbar_route_table.sv
xbar_switch.sv
xbar_rd_resp_merge.sv
xbar_regport_top.sv
tb_xbar.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_xbar
FILELIST  = project.f
OBJ_DIR   = obj_dir
PASS_MSG  = *** PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
